//--- compile.f
hdl/ao_periph_pkg.sv
hdl/obi_to_reg_bridge.sv
hdl/ao_reg_demux.sv
hdl/soc_ctrl.sv
hdl/fast_intr_ctrl.sv
hdl/ao_timer.sv
hdl/ao_peripheral_subsystem.sv
testbench/tb_ao_peripheral_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status is non-zero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_ao_peripheral_subsystem \
  --Mdir obj_dir -o sim_tb \
  -f compile.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit "$status"
fi

exit 0

//--- testbench/tb_ao_peripheral_subsystem.sv
/*
 * Random-stimulus testbench for the always-on peripheral subsystem.
 * OBI accesses are checked against a register model kept here.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ao_peripheral_subsystem;
  import ao_periph_pkg::*;

  localparam addr_t       AO_BASE  = 32'h2000_0000;
  localparam int unsigned SEED     = 32'h5e19bac1;
  localparam int          N_RANDOM = 200;
  localparam int          N_SOC    = 40;
  localparam int          N_FI     = 40;
  localparam int          N_TMR    = 30;
  localparam int          N_IRQ    = 8;
  localparam int          N_UNMAP  = 40;
  localparam int          PLANNED_TXN = N_RANDOM + 5 * N_SOC + 6 * N_FI + 4 * N_TMR +
                                        10 * N_IRQ + 2 * N_UNMAP + 12;
  localparam int          TIMEOUT_CYCLES = 40 * PLANNED_TXN + 2000;

  localparam periph_idx_t P_SOC = periph_idx_t'(SOC_CTRL_IDX);
  localparam periph_idx_t P_FI  = periph_idx_t'(FAST_INTR_IDX);
  localparam periph_idx_t P_TMR = periph_idx_t'(TIMER_IDX);

  logic       clk;
  logic       rst_n;
  obi_req_t   slave_req;
  obi_resp_t  slave_resp;
  logic       boot_select;
  logic       exit_valid;
  word_t      exit_value;
  fast_intr_t fast_intr_in;
  fast_intr_t fast_intr_out;
  logic       timer_intr;
  int         cycle_cnt;

  // Register model
  logic       mdl_exit_valid;
  word_t      mdl_exit_value;
  fast_intr_t mdl_fi_pending;
  fast_intr_t mdl_fi_enable;
  word_t      mdl_tmr_value;
  word_t      mdl_tmr_compare;
  logic       mdl_tmr_en;
  logic       mdl_tmr_status;

  ao_peripheral_subsystem #(
    .AO_BASE_ADDR (AO_BASE),
    .TIMER_W      (32)
  ) dut_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .slave_req_i   (slave_req),
    .slave_resp_o  (slave_resp),
    .boot_select_i (boot_select),
    .exit_valid_o  (exit_valid),
    .exit_value_o  (exit_value),
    .fast_intr_i   (fast_intr_in),
    .fast_intr_o   (fast_intr_out),
    .timer_intr_o  (timer_intr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic fail_and_stop(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    fail_and_stop($sformatf("Timeout: the run did not finish within %0d cycles",
                            TIMEOUT_CYCLES));
  end

  task automatic check_word(input string what, input word_t got, input word_t exp);
    assert (got == exp) else
      fail_and_stop($sformatf("Error at %0t: %s is 0x%08h, expected 0x%08h",
                              $time, what, got, exp));
  endtask

  // Only the enabled bytes of new_v replace those of old_v
  function automatic word_t byte_merge(word_t old_v, word_t new_v, strb_t be);
    word_t r;
    r = old_v;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        r[b*8 +: 8] = new_v[b*8 +: 8];
      end
    end
    return r;
  endfunction

  function automatic addr_t reg_addr(periph_idx_t idx, logic [3:0] ofs);
    return {AO_BASE[31:14], idx, 8'h00, ofs};
  endfunction

  function automatic logic is_mapped(addr_t a);
    return (a[31:14] == AO_BASE[31:14]) && (a[13:12] != 2'd3);
  endfunction

  function automatic addr_t unmapped_addr();
    addr_t a;
    a = addr_t'($urandom) & 32'hFFFF_FFFC;
    if ($urandom % 2 == 0) begin
      a[31:14] = AO_BASE[31:14];
      a[13:12] = 2'd3;
    end else if (a[31:14] == AO_BASE[31:14]) begin
      a[31] = ~a[31];
    end
    return a;
  endfunction

  function automatic word_t expected_read(addr_t a);
    word_t r;
    r = '0;
    if (is_mapped(a)) begin
      if (a[13:12] == P_SOC) begin
        if (a[3:2] == EXIT_VALID_OFS[3:2]) r[0] = mdl_exit_valid;
        else if (a[3:2] == EXIT_VALUE_OFS[3:2]) r = mdl_exit_value;
        else if (a[3:2] == BOOT_SELECT_OFS[3:2]) r[0] = boot_select;
      end else if (a[13:12] == P_FI) begin
        if (a[3:2] == FI_PENDING_OFS[3:2]) r = word_t'(mdl_fi_pending);
        else if (a[3:2] == FI_ENABLE_OFS[3:2]) r = word_t'(mdl_fi_enable);
      end else begin
        if (a[3:2] == TMR_VALUE_OFS[3:2]) r = mdl_tmr_value;
        else if (a[3:2] == TMR_COMPARE_OFS[3:2]) r = mdl_tmr_compare;
        else if (a[3:2] == TMR_CTRL_OFS[3:2]) r[0] = mdl_tmr_en;
        else r[0] = mdl_tmr_status;
      end
    end
    return r;
  endfunction

  task automatic model_write(input addr_t a, input strb_t be, input word_t wdata);
    word_t mask;
    mask = byte_merge(32'h0, 32'hFFFF_FFFF, be);
    if (is_mapped(a)) begin
      if (a[13:12] == P_SOC) begin
        if (a[3:2] == EXIT_VALID_OFS[3:2] && be[0]) mdl_exit_valid = wdata[0];
        if (a[3:2] == EXIT_VALUE_OFS[3:2])
          mdl_exit_value = byte_merge(mdl_exit_value, wdata, be);
      end else if (a[13:12] == P_FI) begin
        // Write one to clear
        if (a[3:2] == FI_PENDING_OFS[3:2])
          mdl_fi_pending = mdl_fi_pending & ~fast_intr_t'(wdata & mask);
        if (a[3:2] == FI_ENABLE_OFS[3:2])
          mdl_fi_enable = fast_intr_t'(byte_merge(word_t'(mdl_fi_enable), wdata, be));
      end else begin
        if (a[3:2] == TMR_VALUE_OFS[3:2])
          mdl_tmr_value = byte_merge(mdl_tmr_value, wdata, be);
        if (a[3:2] == TMR_COMPARE_OFS[3:2])
          mdl_tmr_compare = byte_merge(mdl_tmr_compare, wdata, be);
        if (a[3:2] == TMR_CTRL_OFS[3:2] && be[0]) mdl_tmr_en = wdata[0];
        if (a[3:2] == TMR_STATUS_OFS[3:2] && be[0] && wdata[0]) mdl_tmr_status = 1'b0;
      end
    end
  endtask

  task automatic check_outputs();
    check_word("exit_valid_o", word_t'(exit_valid), word_t'(mdl_exit_valid));
    check_word("exit_value_o", exit_value, mdl_exit_value);
    check_word("fast_intr_o", word_t'(fast_intr_out),
               word_t'(mdl_fi_pending & mdl_fi_enable));
    check_word("timer_intr_o", word_t'(timer_intr), word_t'(mdl_tmr_status));
  endtask

  // One OBI transaction, with the grant to rvalid timing checked
  task automatic obi_access(input logic we, input addr_t addr, input strb_t be,
                            input word_t wdata, output word_t rdata);
    int gnt_cycle;
    @(posedge clk);
    slave_req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    @(negedge clk);
    while (!slave_resp.gnt) @(negedge clk);
    gnt_cycle = cycle_cnt;
    @(posedge clk);
    slave_req.req <= 1'b0;
    @(negedge clk);
    while (!slave_resp.rvalid) @(negedge clk);
    check_word("gnt to rvalid cycles", word_t'(cycle_cnt - gnt_cycle), 32'd2);
    rdata = slave_resp.rdata;
    @(negedge clk);
    check_word("rvalid after its pulse", word_t'(slave_resp.rvalid), 32'd0);
  endtask

  task automatic reg_write(input addr_t addr, input strb_t be, input word_t wdata);
    word_t rd;
    obi_access(1'b1, addr, be, wdata, rd);
    model_write(addr, be, wdata);
    check_word("write rdata", rd, 32'd0);
    check_outputs();
  endtask

  task automatic reg_read_check(input addr_t addr);
    word_t rd;
    word_t exp;
    exp = expected_read(addr);
    obi_access(1'b0, addr, 4'hF, $urandom, rd);
    check_word($sformatf("read of 0x%08h", addr), rd, exp);
    check_outputs();
  endtask

  task automatic pulse_fast_intr(input fast_intr_t lines);
    @(posedge clk);
    fast_intr_in <= lines;
    @(posedge clk);
    fast_intr_in <= '0;
    mdl_fi_pending = mdl_fi_pending | lines;
    @(negedge clk);
    @(negedge clk);
    check_outputs();
  endtask

  initial begin
    periph_idx_t idx;
    logic [3:0]  ofs;
    addr_t       addr;
    word_t       rd;
    word_t       v;
    word_t       d;
    int          waited;

    void'($urandom(SEED));
    cycle_cnt       = 0;
    rst_n           = 1'b0;
    slave_req       = '0;
    boot_select     = 1'b0;
    fast_intr_in    = '0;
    mdl_exit_valid  = 1'b0;
    mdl_exit_value  = '0;
    mdl_fi_pending  = '0;
    mdl_fi_enable   = '0;
    mdl_tmr_value   = '0;
    mdl_tmr_compare = '0;
    mdl_tmr_en      = 1'b0;
    mdl_tmr_status  = 1'b0;

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_word("outputs after reset", word_t'({slave_resp.gnt, slave_resp.rvalid, exit_valid,
               fast_intr_out, timer_intr}), 32'd0);

    // Mixed traffic, timer kept stopped
    for (int i = 0; i < N_RANDOM; i++) begin
      idx  = periph_idx_t'($urandom % 3);
      ofs  = {2'($urandom), 2'b00};
      addr = reg_addr(idx, ofs);
      if ($urandom % 2 == 0 && !(idx == P_TMR && ofs == TMR_CTRL_OFS)) begin
        reg_write(addr, strb_t'($urandom), $urandom);
      end else begin
        reg_read_check(addr);
      end
    end

    for (int i = 0; i < N_SOC; i++) begin
      @(posedge clk);
      boot_select <= 1'($urandom);
      reg_write(reg_addr(P_SOC, EXIT_VALUE_OFS), strb_t'($urandom), $urandom);
      reg_read_check(reg_addr(P_SOC, EXIT_VALUE_OFS));
      reg_write(reg_addr(P_SOC, EXIT_VALID_OFS), strb_t'($urandom), $urandom);
      reg_read_check(reg_addr(P_SOC, EXIT_VALID_OFS));
      reg_read_check(reg_addr(P_SOC, BOOT_SELECT_OFS));
    end

    for (int i = 0; i < N_FI; i++) begin
      reg_write(reg_addr(P_FI, FI_ENABLE_OFS), strb_t'($urandom), $urandom);
      reg_read_check(reg_addr(P_FI, FI_ENABLE_OFS));
      pulse_fast_intr(fast_intr_t'($urandom));
      reg_read_check(reg_addr(P_FI, FI_PENDING_OFS));
      // Sparse clear pattern keeps some bits pending
      reg_write(reg_addr(P_FI, FI_PENDING_OFS), strb_t'($urandom), $urandom & $urandom);
      reg_read_check(reg_addr(P_FI, FI_PENDING_OFS));
    end

    for (int i = 0; i < N_TMR; i++) begin
      reg_write(reg_addr(P_TMR, TMR_VALUE_OFS), strb_t'($urandom), $urandom);
      reg_write(reg_addr(P_TMR, TMR_COMPARE_OFS), strb_t'($urandom), $urandom);
      reg_read_check(reg_addr(P_TMR, TMR_VALUE_OFS));
      reg_read_check(reg_addr(P_TMR, TMR_COMPARE_OFS));
    end

    for (int i = 0; i < N_IRQ; i++) begin
      v = $urandom & 32'h7FFF_FFFF;
      d = 32'd1 + ($urandom % 32'd50);
      reg_write(reg_addr(P_TMR, TMR_VALUE_OFS), 4'hF, v);
      reg_write(reg_addr(P_TMR, TMR_COMPARE_OFS), 4'hF, v + d);
      reg_write(reg_addr(P_TMR, TMR_CTRL_OFS), 4'h1, 32'd1);
      waited = 0;
      while (!timer_intr && waited <= int'(d) + 4) begin
        @(negedge clk);
        waited++;
      end
      assert (timer_intr) else
        fail_and_stop($sformatf("Error at %0t: timer interrupt did not rise within %0d cycles",
                                $time, int'(d) + 4));
      mdl_tmr_status = 1'b1;
      obi_access(1'b0, reg_addr(P_TMR, TMR_VALUE_OFS), 4'hF, 32'd0, rd);
      assert (rd >= mdl_tmr_compare) else
        fail_and_stop($sformatf("Error at %0t: timer value 0x%08h is below compare 0x%08h",
                                $time, rd, mdl_tmr_compare));
      reg_write(reg_addr(P_TMR, TMR_STATUS_OFS), 4'h1, 32'd1);
      reg_read_check(reg_addr(P_TMR, TMR_STATUS_OFS));
      reg_write(reg_addr(P_TMR, TMR_CTRL_OFS), 4'h1, 32'd0);
      reg_write(reg_addr(P_TMR, TMR_VALUE_OFS), 4'hF, $urandom);
    end

    for (int i = 0; i < N_UNMAP; i++) begin
      addr = unmapped_addr();
      reg_read_check(addr);
      reg_write(unmapped_addr(), strb_t'($urandom), $urandom);
    end
    for (int p = 0; p < 3; p++) begin
      for (int r = 0; r < 4; r++) begin
        reg_read_check(reg_addr(periph_idx_t'(p), {2'(r), 2'b00}));
      end
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/ao_peripheral_subsystem.sv
/*
 * Always-on peripheral subsystem top level.
 * One OBI slave port reaches SoC control, fast interrupts and the timer.
 */
`timescale 1ns/1ps
`default_nettype none

module ao_peripheral_subsystem #(
  parameter ao_periph_pkg::addr_t AO_BASE_ADDR = 32'h2000_0000,
  parameter int unsigned          TIMER_W      = 32
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  input  ao_periph_pkg::obi_req_t   slave_req_i,
  output ao_periph_pkg::obi_resp_t  slave_resp_o,

  // SoC control
  input  logic                      boot_select_i,
  output logic                      exit_valid_o,
  output ao_periph_pkg::word_t      exit_value_o,

  // Fast interrupts
  input  ao_periph_pkg::fast_intr_t fast_intr_i,
  output ao_periph_pkg::fast_intr_t fast_intr_o,

  output logic                      timer_intr_o
);
  import ao_periph_pkg::*;

  reg_req_t                     periph_req;
  reg_rsp_t                     periph_rsp;
  reg_req_t [NUM_AO_PERIPH-1:0] ao_slv_req;
  reg_rsp_t [NUM_AO_PERIPH-1:0] ao_slv_rsp;

  obi_to_reg_bridge obi_to_reg_bridge_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .obi_req_i  (slave_req_i),
    .obi_resp_o (slave_resp_o),
    .reg_req_o  (periph_req),
    .reg_rsp_i  (periph_rsp)
  );

  ao_reg_demux #(
    .AO_BASE_ADDR (AO_BASE_ADDR)
  ) ao_reg_demux_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .in_req_i  (periph_req),
    .in_rsp_o  (periph_rsp),
    .out_req_o (ao_slv_req),
    .out_rsp_i (ao_slv_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_req_i     (ao_slv_req[SOC_CTRL_IDX]),
    .reg_rsp_o     (ao_slv_rsp[SOC_CTRL_IDX]),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (ao_slv_req[FAST_INTR_IDX]),
    .reg_rsp_o   (ao_slv_rsp[FAST_INTR_IDX]),
    .fast_intr_i (fast_intr_i),
    .fast_intr_o (fast_intr_o)
  );

  ao_timer #(
    .TIMER_W (TIMER_W)
  ) ao_timer_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .reg_req_i    (ao_slv_req[TIMER_IDX]),
    .reg_rsp_o    (ao_slv_rsp[TIMER_IDX]),
    .timer_intr_o (timer_intr_o)
  );

endmodule

`default_nettype wire

//--- hdl/ao_timer.sv
/*
 * Always-on compare timer. The counter runs while CTRL bit 0 is set and
 * a match with COMPARE sets a sticky status bit that drives the interrupt.
 */
`timescale 1ns/1ps
`default_nettype none

module ao_timer #(
  parameter int unsigned TIMER_W = 32
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                    timer_intr_o
);
  import ao_periph_pkg::*;

  typedef logic [TIMER_W-1:0] count_t;

  count_t     count_q;
  count_t     compare_q;
  logic       en_q;
  logic       status_q;
  logic       wr_en;
  logic [1:0] reg_sel;
  word_t      rdata;

  assign wr_en   = reg_req_i.valid && reg_req_i.write;
  assign reg_sel = reg_req_i.addr[3:2];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q   <= '0;
      compare_q <= '0;
      en_q      <= 1'b0;
      status_q  <= 1'b0;
    end else begin
      // Software write takes priority over counting
      if (wr_en && reg_sel == TMR_VALUE_OFS[3:2]) begin
        count_q <= count_t'(apply_strb(word_t'(count_q), reg_req_i.wdata, reg_req_i.wstrb));
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr_en && reg_sel == TMR_COMPARE_OFS[3:2]) begin
        compare_q <= count_t'(apply_strb(word_t'(compare_q), reg_req_i.wdata,
                                         reg_req_i.wstrb));
      end
      if (wr_en && reg_sel == TMR_CTRL_OFS[3:2] && reg_req_i.wstrb[0]) begin
        en_q <= reg_req_i.wdata[0];
      end
      if (en_q && count_q == compare_q) begin
        status_q <= 1'b1;
      end else if (wr_en && reg_sel == TMR_STATUS_OFS[3:2] &&
                   reg_req_i.wstrb[0] && reg_req_i.wdata[0]) begin
        status_q <= 1'b0;
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (reg_sel)
      TMR_VALUE_OFS[3:2]:   rdata = word_t'(count_q);
      TMR_COMPARE_OFS[3:2]: rdata = word_t'(compare_q);
      TMR_CTRL_OFS[3:2]:    rdata[0] = en_q;
      TMR_STATUS_OFS[3:2]:  rdata[0] = status_q;
      default:              rdata = '0;
    endcase
  end

  assign reg_rsp_o    = '{ready: 1'b1, rdata: rdata};
  assign timer_intr_o = status_q;

  a_intr_while_enabled: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $rose(timer_intr_o) |-> $past(en_q));

endmodule

`default_nettype wire

//--- hdl/fast_intr_ctrl.sv
/*
 * Fast interrupt controller with sticky pending bits and an enable mask.
 * Pending bits are cleared by writing ones.
 */
`timescale 1ns/1ps
`default_nettype none

module fast_intr_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  ao_periph_pkg::reg_req_t   reg_req_i,
  output ao_periph_pkg::reg_rsp_t   reg_rsp_o,
  input  ao_periph_pkg::fast_intr_t fast_intr_i,
  output ao_periph_pkg::fast_intr_t fast_intr_o
);
  import ao_periph_pkg::*;

  fast_intr_t pending_q;
  fast_intr_t enable_q;
  fast_intr_t clr;
  logic       pend_wr;
  logic       en_wr;
  word_t      rdata;

  assign pend_wr = reg_req_i.valid && reg_req_i.write &&
                   (reg_req_i.addr[3:2] == FI_PENDING_OFS[3:2]);
  assign en_wr   = reg_req_i.valid && reg_req_i.write &&
                   (reg_req_i.addr[3:2] == FI_ENABLE_OFS[3:2]);
  assign clr     = pend_wr ?
                   fast_intr_t'(reg_req_i.wdata & strb_to_mask(reg_req_i.wstrb)) : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q   <= '0;
      enable_q    <= '0;
      fast_intr_o <= '0;
    end else begin
      // A new edge wins over a clear in the same cycle
      pending_q   <= (pending_q & ~clr) | fast_intr_i;
      fast_intr_o <= pending_q & enable_q;
      if (en_wr) begin
        enable_q <= fast_intr_t'(apply_strb(word_t'(enable_q), reg_req_i.wdata,
                                            reg_req_i.wstrb));
      end
    end
  end

  always_comb begin
    case (reg_req_i.addr[3:2])
      FI_PENDING_OFS[3:2]: rdata = word_t'(pending_q);
      FI_ENABLE_OFS[3:2]:  rdata = word_t'(enable_q);
      default:             rdata = '0;
    endcase
  end

  assign reg_rsp_o = '{ready: 1'b1, rdata: rdata};

endmodule

`default_nettype wire

//--- hdl/soc_ctrl.sv
/*
 * SoC control registers: exit flag, exit value and boot select status.
 * Software sets the exit flag and value to end a run.
 */
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic                    boot_select_i,
  output logic                    exit_valid_o,
  output ao_periph_pkg::word_t    exit_value_o
);
  import ao_periph_pkg::*;

  logic       wr_en;
  logic [1:0] reg_sel;
  word_t      rdata;

  assign wr_en   = reg_req_i.valid && reg_req_i.write;
  assign reg_sel = reg_req_i.addr[3:2];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
    end else if (wr_en) begin
      if (reg_sel == EXIT_VALID_OFS[3:2] && reg_req_i.wstrb[0]) begin
        exit_valid_o <= reg_req_i.wdata[0];
      end
      if (reg_sel == EXIT_VALUE_OFS[3:2]) begin
        exit_value_o <= apply_strb(exit_value_o, reg_req_i.wdata, reg_req_i.wstrb);
      end
    end
  end

  // Boot select is read only
  always_comb begin
    rdata = '0;
    case (reg_sel)
      EXIT_VALID_OFS[3:2]:  rdata[0] = exit_valid_o;
      EXIT_VALUE_OFS[3:2]:  rdata = exit_value_o;
      BOOT_SELECT_OFS[3:2]: rdata[0] = boot_select_i;
      default:              rdata = '0;
    endcase
  end

  assign reg_rsp_o = '{ready: 1'b1, rdata: rdata};

endmodule

`default_nettype wire

//--- hdl/ao_reg_demux.sv
/*
 * Register bus demultiplexer for the always-on peripherals.
 * Unmapped accesses are answered here with ready and zero data.
 */
`timescale 1ns/1ps
`default_nettype none

module ao_reg_demux #(
  parameter ao_periph_pkg::addr_t AO_BASE_ADDR = 32'h2000_0000
) (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  input  ao_periph_pkg::reg_req_t                                  in_req_i,
  output ao_periph_pkg::reg_rsp_t                                  in_rsp_o,
  output ao_periph_pkg::reg_req_t [ao_periph_pkg::NUM_AO_PERIPH-1:0] out_req_o,
  input  ao_periph_pkg::reg_rsp_t [ao_periph_pkg::NUM_AO_PERIPH-1:0] out_rsp_i
);
  import ao_periph_pkg::*;

  periph_idx_t              sel;
  logic                     mapped;
  logic [NUM_AO_PERIPH-1:0] port_valid;

  // Bits 13:12 pick the peripheral inside the 16 KiB window
  assign sel    = in_req_i.addr[13:12];
  assign mapped = (in_req_i.addr[31:14] == AO_BASE_ADDR[31:14]) && (sel < NUM_AO_PERIPH);

  always_comb begin
    in_rsp_o = '{ready: 1'b1, rdata: '0};
    for (int i = 0; i < NUM_AO_PERIPH; i++) begin
      port_valid[i]      = in_req_i.valid && mapped && (sel == periph_idx_t'(i));
      out_req_o[i]       = in_req_i;
      out_req_o[i].valid = port_valid[i];
      if (mapped && (sel == periph_idx_t'(i))) begin
        in_rsp_o = out_rsp_i[i];
      end
    end
  end

  a_single_target: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $onehot0(port_valid));

endmodule

`default_nettype wire

//--- hdl/obi_to_reg_bridge.sv
/*
 * Turns single OBI slave transactions into register bus accesses.
 * Grant, one access cycle, then a one-cycle rvalid pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module obi_to_reg_bridge (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ao_periph_pkg::obi_req_t  obi_req_i,
  output ao_periph_pkg::obi_resp_t obi_resp_o,
  output ao_periph_pkg::reg_req_t  reg_req_o,
  input  ao_periph_pkg::reg_rsp_t  reg_rsp_i
);
  import ao_periph_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESPOND
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   accept;
  logic   we_q;
  addr_t  addr_q;
  strb_t  be_q;
  word_t  wdata_q;
  word_t  rdata_q;

  // RESPOND frees the bridge, so a new request may be granted there
  assign accept = obi_req_i.req && (state_q != ACCESS);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    state_d = accept ? ACCESS : IDLE;
      ACCESS:  state_d = reg_rsp_i.ready ? RESPOND : ACCESS;
      RESPOND: state_d = accept ? ACCESS : IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q    <= obi_req_i.we;
      addr_q  <= obi_req_i.addr;
      be_q    <= obi_req_i.be;
      wdata_q <= obi_req_i.wdata;
    end
    if (state_q == ACCESS && reg_rsp_i.ready) begin
      rdata_q <= we_q ? '0 : reg_rsp_i.rdata;
    end
  end

  assign obi_resp_o = '{gnt: accept, rvalid: (state_q == RESPOND), rdata: rdata_q};

  assign reg_req_o = '{
    valid: (state_q == ACCESS),
    write: we_q,
    addr:  addr_q,
    wdata: wdata_q,
    wstrb: be_q
  };

  a_no_rvalid_after_reset: assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> !obi_resp_o.rvalid);

  // Targets are always ready, so every grant completes two cycles later
  a_gnt_to_rvalid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    obi_resp_o.gnt |-> ##2 obi_resp_o.rvalid);

endmodule

`default_nettype wire

//--- hdl/ao_periph_pkg.sv
/*
 * Shared types and constants for the always-on peripheral subsystem.
 * Bus structs, width types, peripheral indices and register offsets.
 */
`default_nettype none

package ao_periph_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  strb_t;
  typedef logic [14:0] fast_intr_t;
  typedef logic [1:0]  periph_idx_t;

  typedef struct packed {
    logic  req;
    logic  we;
    strb_t be;
    addr_t addr;
    word_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
  } obi_resp_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
  } reg_req_t;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } reg_rsp_t;

  localparam int unsigned SOC_CTRL_IDX  = 0;
  localparam int unsigned FAST_INTR_IDX = 1;
  localparam int unsigned TIMER_IDX     = 2;
  localparam int unsigned NUM_AO_PERIPH = 3;

  // Only bits 3:2 are decoded by the peripherals
  localparam logic [3:0] EXIT_VALID_OFS  = 4'h0;
  localparam logic [3:0] EXIT_VALUE_OFS  = 4'h4;
  localparam logic [3:0] BOOT_SELECT_OFS = 4'h8;

  localparam logic [3:0] FI_PENDING_OFS = 4'h0;
  localparam logic [3:0] FI_ENABLE_OFS  = 4'h4;

  localparam logic [3:0] TMR_VALUE_OFS   = 4'h0;
  localparam logic [3:0] TMR_COMPARE_OFS = 4'h4;
  localparam logic [3:0] TMR_CTRL_OFS    = 4'h8;
  localparam logic [3:0] TMR_STATUS_OFS  = 4'hC;

  // Expand byte enables to a bit mask
  function automatic word_t strb_to_mask(strb_t strb);
    word_t mask;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return mask;
  endfunction

  function automatic word_t apply_strb(word_t old_val, word_t new_val, strb_t strb);
    word_t mask;
    mask = strb_to_mask(strb);
    return (old_val & ~mask) | (new_val & mask);
  endfunction

endpackage

`default_nettype wire
